// File: logic/core_pkg.sv
package core_pkg;

    localparam int MEM_WORDS_LOG2 = 6; // 64 words of program memory

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [MEM_WORDS_LOG2-1:0] mem_addr_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        ISA_OPCODE_OP       = 7'b0110011,
        ISA_OPCODE_OP_IMMED = 7'b0010011,
        ISA_OPCODE_ENV      = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_CTRL_ADD  = 4'd0,
        ALU_CTRL_SUB  = 4'd1,
        ALU_CTRL_AND  = 4'd2,
        ALU_CTRL_OR   = 4'd3,
        ALU_CTRL_XOR  = 4'd4,
        ALU_CTRL_SLT  = 4'd5,
        ALU_CTRL_SLTU = 4'd6,
        ALU_CTRL_SLL  = 4'd7,
        ALU_CTRL_SRL  = 4'd8,
        ALU_CTRL_SRA  = 4'd9
    } alu_ctrl_t;

    typedef enum logic [1:0] {
        UNIT_SEL_NONE = 2'd0,
        UNIT_SEL_MEM  = 2'd1,
        UNIT_SEL_ALU  = 2'd2
    } unit_sel_t;

    typedef enum logic [0:0] {
        MEM_CTRL_READ = 1'b0
    } mem_ctrl_t;

    typedef enum logic [2:0] {
        THREAD_STATE_INIT     = 3'd0,
        THREAD_STATE_FETCH_0  = 3'd1,
        THREAD_STATE_FETCH_1  = 3'd2,
        THREAD_STATE_OP       = 3'd3,
        THREAD_STATE_OP_IMMED = 3'd4,
        THREAD_STATE_INC_PC   = 3'd5,
        THREAD_STATE_BREAK    = 3'd6
    } thread_state_t;

    // register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_t    opcode;
    } r_fmt_s;

    // register-immediate layout
    typedef struct packed {
        logic [11:0] imm12;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_t     opcode;
    } i_fmt_s;

    typedef union packed {
        word_t  raw;
        r_fmt_s r_fmt;
        i_fmt_s i_fmt;
    } inst_u;

    // request from the thread to whichever unit sel names
    typedef struct packed {
        unit_sel_t                     sel;
        logic [$bits(alu_ctrl_t)-1:0]  ctrl; // alu_ctrl_t or mem_ctrl_t
        word_t                         in0;
        word_t                         in1;
    } unit_req_s;

    typedef struct packed {
        mem_addr_t addr;
        word_t     data;
    } load_s;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } retire_s;

endpackage

// File: logic/reg_file.sv
`timescale 1ns/100ps

module reg_file import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      write_en,
    input  reg_addr_t rd_addr,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  word_t     rd_data,
    output word_t     rs1_data,
    output word_t     rs2_data
);
    word_t regs [32];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && rd_addr != '0) begin // x0 stays zero
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: logic/inst_decode.sv
`timescale 1ns/100ps

module inst_decode import core_pkg::*; (
    input  inst_u     inst,
    output alu_ctrl_t alu_ctrl,
    output word_t     immed
);
    logic is_op;
    logic alt; // funct7 bit 5 selects sub / sra

    assign is_op = (inst.r_fmt.opcode == ISA_OPCODE_OP);
    assign alt = inst.r_fmt.funct7[5];

    always_comb begin
        case (inst.r_fmt.funct3)
            3'b000: begin
                if (is_op && alt) begin
                    alu_ctrl = ALU_CTRL_SUB;
                end else begin
                    alu_ctrl = ALU_CTRL_ADD; // addi has no sub form
                end
            end
            3'b001: alu_ctrl = ALU_CTRL_SLL;
            3'b010: alu_ctrl = ALU_CTRL_SLT;
            3'b011: alu_ctrl = ALU_CTRL_SLTU;
            3'b100: alu_ctrl = ALU_CTRL_XOR;
            3'b101: begin
                if (alt) begin
                    alu_ctrl = ALU_CTRL_SRA; // also srai
                end else begin
                    alu_ctrl = ALU_CTRL_SRL;
                end
            end
            3'b110: alu_ctrl = ALU_CTRL_OR;
            default: alu_ctrl = ALU_CTRL_AND;
        endcase
    end

    assign immed = {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};

endmodule

// File: logic/alu.sv
`timescale 1ns/100ps

module alu import core_pkg::*; (
    input  alu_ctrl_t ctrl,
    input  word_t     a,
    input  word_t     b,
    output word_t     y
);
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (ctrl)
            ALU_CTRL_ADD:  y = a + b;
            ALU_CTRL_SUB:  y = a - b;
            ALU_CTRL_AND:  y = a & b;
            ALU_CTRL_OR:   y = a | b;
            ALU_CTRL_XOR:  y = a ^ b;
            ALU_CTRL_SLT:  y = {31'd0, $signed(a) < $signed(b)};
            ALU_CTRL_SLTU: y = {31'd0, a < b};
            ALU_CTRL_SLL:  y = a << shamt;
            ALU_CTRL_SRL:  y = a >> shamt;
            ALU_CTRL_SRA:  y = word_t'($signed(a) >>> shamt);
            default:       y = '0;
        endcase
    end

endmodule

// File: logic/thread.sv
`timescale 1ns/100ps

module thread import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      run,
    input  word_t     unit_out,
    output unit_req_s unit_req,
    output retire_s   retire,
    output logic      halted
);
    thread_state_t state;
    thread_state_t next_state;
    logic [2:0] ic; // step within the current instruction
    logic [2:0] next_ic;
    word_t pc;
    word_t next_pc;
    inst_u inst;
    inst_u next_inst;

    logic write_en;
    reg_addr_t rd_addr;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t rs1_data;
    word_t rs2_data;
    word_t wb_data;

    alu_ctrl_t alu_ctrl;
    word_t immed;

    reg_file reg_file_i (
        .clk      (clk),
        .rst      (rst),
        .write_en (write_en),
        .rd_addr  (rd_addr),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_data  (unit_out),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    inst_decode inst_decode_i (
        .inst     (inst),
        .alu_ctrl (alu_ctrl),
        .immed    (immed)
    );

    assign wb_data = (rd_addr == '0) ? '0 : unit_out; // x0 reads back as zero
    assign halted = (state == THREAD_STATE_BREAK);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= THREAD_STATE_INIT;
            ic <= '0;
            pc <= '0;
            inst <= '0;
            retire <= '0;
        end else begin
            state <= next_state;
            ic <= next_ic;
            pc <= next_pc;
            inst <= next_inst;
            retire.valid <= write_en;
            retire.rd <= rd_addr;
            retire.data <= wb_data;
        end
    end

    always_comb begin
        next_ic = ic;
        next_pc = pc;
        next_inst = inst;
        unit_req.sel = UNIT_SEL_NONE;
        unit_req.ctrl = '0;
        unit_req.in0 = '0;
        unit_req.in1 = '0;
        write_en = 1'b0;
        rd_addr = '0;
        rs1_addr = '0;
        rs2_addr = '0;

        case (state)
            THREAD_STATE_INIT: begin
                next_ic = '0;
                next_pc = '0;
                next_inst = '0;
            end
            THREAD_STATE_FETCH_0: begin
                next_ic = 3'd1;
                unit_req.sel = UNIT_SEL_MEM;
                unit_req.ctrl = 4'(MEM_CTRL_READ);
                unit_req.in0 = pc;
            end
            THREAD_STATE_FETCH_1: begin
                next_ic = ic + 3'd1;
                next_inst.raw = unit_out;
                unit_req.sel = UNIT_SEL_MEM;
                unit_req.ctrl = 4'(MEM_CTRL_READ);
                unit_req.in0 = pc;
            end
            THREAD_STATE_OP: begin
                next_ic = ic + 3'd1;
                unit_req.sel = UNIT_SEL_ALU;
                unit_req.ctrl = alu_ctrl;
                unit_req.in0 = rs1_data;
                unit_req.in1 = rs2_data;
                write_en = 1'b1;
                rd_addr = inst.r_fmt.rd;
                rs1_addr = inst.r_fmt.rs1;
                rs2_addr = inst.r_fmt.rs2;
            end
            THREAD_STATE_OP_IMMED: begin
                next_ic = ic + 3'd1;
                unit_req.sel = UNIT_SEL_ALU;
                unit_req.ctrl = alu_ctrl;
                unit_req.in0 = rs1_data;
                unit_req.in1 = immed;
                write_en = 1'b1;
                rd_addr = inst.i_fmt.rd;
                rs1_addr = inst.i_fmt.rs1;
            end
            THREAD_STATE_INC_PC: begin
                next_ic = ic + 3'd1;
                next_pc = unit_out;
                unit_req.sel = UNIT_SEL_ALU;
                unit_req.ctrl = ALU_CTRL_ADD;
                unit_req.in0 = pc;
                unit_req.in1 = 32'd4;
            end
            THREAD_STATE_BREAK: begin
            end
            default: begin
                next_ic = '0;
                next_pc = '0;
                next_inst = '0;
            end
        endcase
    end

    // next state from the opcode of the word being held and the step count
    always_comb begin
        case (next_inst.r_fmt.opcode)
            ISA_OPCODE_OP: begin
                case (next_ic)
                    3'd1: next_state = THREAD_STATE_FETCH_1;
                    3'd2: next_state = THREAD_STATE_OP;
                    3'd3: next_state = THREAD_STATE_INC_PC;
                    default: next_state = THREAD_STATE_FETCH_0;
                endcase
            end
            ISA_OPCODE_OP_IMMED: begin
                case (next_ic)
                    3'd1: next_state = THREAD_STATE_FETCH_1;
                    3'd2: next_state = THREAD_STATE_OP_IMMED;
                    3'd3: next_state = THREAD_STATE_INC_PC;
                    default: next_state = THREAD_STATE_FETCH_0;
                endcase
            end
            default: begin // env and unknown opcodes stop the thread
                case (next_ic)
                    3'd1: next_state = THREAD_STATE_FETCH_1;
                    3'd2: next_state = THREAD_STATE_BREAK;
                    default: next_state = THREAD_STATE_FETCH_0;
                endcase
            end
        endcase
        if (state == THREAD_STATE_INIT && !run) begin
            next_state = THREAD_STATE_INIT; // hold until released
        end
    end

    state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {THREAD_STATE_INIT, THREAD_STATE_FETCH_0, THREAD_STATE_FETCH_1,
                      THREAD_STATE_OP, THREAD_STATE_OP_IMMED, THREAD_STATE_INC_PC,
                      THREAD_STATE_BREAK});

endmodule

// File: logic/unit_mem.sv
`timescale 1ns/100ps

module unit_mem import core_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  run,
    input  word_t rd_addr,
    input  load_s load,
    input  logic  load_req,
    output word_t rd_data,
    output logic  load_ack
);
    word_t mem [2**MEM_WORDS_LOG2];
    mem_addr_t rd_index;
    logic load_take;

    assign rd_index = rd_addr[MEM_WORDS_LOG2+1:2]; // byte address to word index

    // a new request is taken once, while the thread is held
    assign load_take = load_req && !load_ack && !run;

    always_ff @(posedge clk) begin
        if (load_take) begin
            mem[load.addr] <= load.data;
        end
        rd_data <= mem[rd_index];
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            load_ack <= 1'b0;
        end else if (load_take) begin
            load_ack <= 1'b1;
        end else if (!load_req) begin
            load_ack <= 1'b0; // closes the four-phase cycle
        end
    end

    req_held_until_ack: assert property (@(posedge clk) disable iff (rst)
        load_req && !load_ack |=> load_req && $stable(load)); // word steady until answered

    no_load_while_run: assert property (@(posedge clk) disable iff (rst)
        load_req |-> !run);

endmodule

// File: logic/core_top.sv
`timescale 1ns/100ps

module core_top import core_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    run,
    input  load_s   load,
    input  logic    load_req,
    output logic    load_ack,
    output retire_s retire,
    output logic    halted
);
    unit_req_s unit_req;
    word_t unit_out;
    word_t alu_y;
    word_t mem_rd_data;

    thread thread_i (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .unit_out (unit_out),
        .unit_req (unit_req),
        .retire   (retire),
        .halted   (halted)
    );

    alu alu_i (
        .ctrl (alu_ctrl_t'(unit_req.ctrl)),
        .a    (unit_req.in0),
        .b    (unit_req.in1),
        .y    (alu_y)
    );

    unit_mem unit_mem_i (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .rd_addr  (unit_req.in0),
        .load     (load),
        .load_req (load_req),
        .rd_data  (mem_rd_data),
        .load_ack (load_ack)
    );

    always_comb begin
        case (unit_req.sel)
            UNIT_SEL_ALU: unit_out = alu_y;
            UNIT_SEL_MEM: unit_out = mem_rd_data; // word addressed last cycle
            default:      unit_out = '0;
        endcase
    end

endmodule

// File: testbench/core_tb.sv
`timescale 1ns/100ps

module core_tb import core_pkg::*; ();
    logic clk = 1'b0;
    logic rst = 1'b1;
    logic run;
    load_s load;
    logic load_req;
    logic load_ack;
    retire_s retire;
    logic halted;

    word_t prog [$];
    reg_addr_t exp_rd [$];
    word_t exp_data [$];
    string exp_name [$];
    word_t model_regs [32]; // architectural view of x0..x31
    int seed;
    int cycle = 0;
    int cycle_limit;
    int last_retire = -1;

    core_top dut_i (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .load     (load),
        .load_req (load_req),
        .load_ack (load_ack),
        .retire   (retire),
        .halted   (halted)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    task automatic end_in_failure();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic flag_mismatch(input string test, input word_t expected, input word_t actual);
        $display("FAIL %s: expected %h, actual %h", test, expected, actual);
        end_in_failure();
    endtask

    task automatic stop_run(input string reason);
        $display("error: %s", reason);
        end_in_failure();
    endtask

    // RV32I result for funct3 and the funct7 alternate bit
    function automatic word_t isa_result(input logic [2:0] funct3, input logic alt,
                                         input word_t a, input word_t b);
        case (funct3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic reg_addr_t pick_src();
        return reg_addr_t'(($random(seed) & 7) + 1); // one of x1..x8
    endfunction

    task automatic record_write(input reg_addr_t rd, input word_t value, input string name);
        if (rd != 5'd0) begin
            model_regs[rd] = value;
        end
        exp_rd.push_back(rd);
        exp_data.push_back(model_regs[rd]); // x0 retires zero
        exp_name.push_back(name);
    endtask

    task automatic put_addi(input reg_addr_t rd, input reg_addr_t rs1, input logic [11:0] imm);
        word_t sum;
        sum = model_regs[rs1] + {{20{imm[11]}}, imm};
        prog.push_back({imm, rs1, 3'b000, rd, 7'b0010011});
        record_write(rd, sum, $sformatf("addi x%0d", rd));
    endtask

    task automatic append_op(input logic [2:0] funct3, input logic alt, input reg_addr_t rd,
                             input reg_addr_t rs1, input reg_addr_t rs2, input string mnem);
        prog.push_back({1'b0, alt, 5'b00000, rs2, rs1, funct3, rd, 7'b0110011});
        record_write(rd, isa_result(funct3, alt, model_regs[rs1], model_regs[rs2]),
                     $sformatf("%s x%0d", mnem, rd));
    endtask

    task automatic build_program();
        seed = 32'hc733;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int r = 1; r <= 7; r++) begin
            put_addi(reg_addr_t'(r), 5'd0, 12'($random(seed)));
        end
        put_addi(5'd8, 5'd1, 12'($random(seed)));
        append_op(3'b000, 1'b0, 5'd9, pick_src(), pick_src(), "add");
        append_op(3'b000, 1'b1, 5'd10, pick_src(), pick_src(), "sub");
        append_op(3'b001, 1'b0, 5'd11, pick_src(), pick_src(), "sll");
        append_op(3'b010, 1'b0, 5'd12, pick_src(), pick_src(), "slt");
        append_op(3'b011, 1'b0, 5'd13, pick_src(), pick_src(), "sltu");
        append_op(3'b100, 1'b0, 5'd14, pick_src(), pick_src(), "xor");
        append_op(3'b101, 1'b0, 5'd15, pick_src(), pick_src(), "srl");
        append_op(3'b101, 1'b1, 5'd16, pick_src(), pick_src(), "sra");
        append_op(3'b110, 1'b0, 5'd17, pick_src(), pick_src(), "or");
        append_op(3'b111, 1'b0, 5'd18, pick_src(), pick_src(), "and");
        append_op(3'b000, 1'b0, 5'd0, 5'd1, 5'd2, "add"); // dropped write to x0
        append_op(3'b110, 1'b0, 5'd19, 5'd0, 5'd3, "or");
        prog.push_back(32'h0000_0073); // ecall halts the thread
    endtask

    task automatic load_word(input mem_addr_t addr, input word_t data);
        load.addr <= addr;
        load.data <= data;
        load_req <= 1'b1;
        @(posedge clk);
        while (!load_ack) begin
            @(posedge clk);
        end
        load_req <= 1'b0;
        @(posedge clk);
        while (load_ack) begin
            @(posedge clk);
        end
    endtask

    ack_after_req: assert property (@(posedge clk) disable iff (rst)
        $rose(load_ack) |-> $past(load_req))
        else stop_run("load_ack rose without a pending load_req");

    ack_after_release: assert property (@(posedge clk) disable iff (rst)
        $fell(load_ack) |-> !$past(load_req))
        else stop_run("load_ack fell while load_req was still high");

    quiet_before_run: assert property (@(posedge clk) disable iff (rst)
        !run |-> !retire.valid && !halted)
        else stop_run("retire or halted was active before run");

    halt_holds: assert property (@(posedge clk) disable iff (rst)
        !$fell(halted))
        else stop_run("halted dropped after the thread stopped");

    always @(negedge clk) begin
        cycle = cycle + 1;
        if (cycle > cycle_limit) begin
            stop_run("timeout, the thread did not halt within the cycle limit");
        end
        if (!rst && retire.valid) begin
            assert (!halted) else stop_run("a retire was seen after the thread halted");
            assert (exp_rd.size() > 0) else stop_run("retire with no instruction left to retire");
            assert (retire.rd == exp_rd[0])
                else flag_mismatch({exp_name[0], " rd"}, 32'(exp_rd[0]), 32'(retire.rd));
            assert (retire.data == exp_data[0])
                else flag_mismatch(exp_name[0], exp_data[0], retire.data);
            assert (last_retire < 0 || cycle - last_retire == 4)
                else flag_mismatch({exp_name[0], " spacing"}, 32'd4, 32'(cycle - last_retire));
            last_retire = cycle;
            void'(exp_rd.pop_front());
            void'(exp_data.pop_front());
            void'(exp_name.pop_front());
        end
    end

    initial begin
        run = 1'b0;
        load_req = 1'b0;
        load = '0;
        build_program();
        cycle_limit = 4 * prog.size() + 200;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        foreach (prog[i]) begin
            load_word(mem_addr_t'(i), prog[i]);
        end
        run <= 1'b1;
        while (!halted) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk); // a stray retire after halt would show up here
        if (exp_rd.size() != 0) begin
            stop_run("the thread halted before every instruction retired");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

// File: tb.f
logic/core_pkg.sv
logic/reg_file.sv
logic/inst_decode.sv
logic/alu.sv
logic/thread.sv
logic/unit_mem.sv
logic/core_top.sv
testbench/core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f tb.f \
    || { echo "build failed"; exit 1; }

out="$(./obj_dir/Vcore_tb 2>&1)"
echo "$out"
echo "$out" | grep -qx "All checks passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
